// ==== common/alu_res_if.sv ====
/*
 * ALU result bundle
 * Shared by the control-flow, load/store and writeback blocks
 */
`default_nettype none

interface alu_res_if import exec_isa_pkg::*; ();

    logic [XLEN-1:0] add_out;                 // lhs + rhs
    logic            cmp_eq;                  // lhs == rhs
    logic            cmp_lt;                  // Signed lhs < rhs
    logic            cmp_ltu;                 // Unsigned lhs < rhs
    logic [XLEN-1:0] result;                  // Selected ALU result

    modport src (output add_out, cmp_eq, cmp_lt, cmp_ltu, result);
    modport snk (input  add_out, cmp_eq, cmp_lt, cmp_ltu, result);

endinterface

`default_nettype wire

// ==== common/exec_isa_pkg.sv ====
/*
 * Execute stage ISA definitions
 * Data and register widths, unit operation codes and trap causes
 */
`default_nettype none

package exec_isa_pkg;

    localparam int XLEN         = 32;         // Data width
    localparam int REG_ADDR_W   = 5;          // Register address width
    localparam int TRAP_CAUSE_W = 7;          // Trap cause width

    // Operation codes
    // --------------------
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_op_e;

    typedef enum logic [3:0] {
        CFU_NONE, CFU_BEQ, CFU_BNE, CFU_BLT, CFU_BGE, CFU_BLTU,
        CFU_BGEU, CFU_JAL, CFU_JALR, CFU_ECALL, CFU_EBRK
    } cfu_op_e;

    typedef enum logic [3:0] {
        LSU_NONE, LSU_LB, LSU_LBU, LSU_LH, LSU_LHU,
        LSU_LW, LSU_SB, LSU_SH, LSU_SW
    } lsu_op_e;

    // Trap causes
    // --------------------
    localparam logic [TRAP_CAUSE_W-1:0] TRAP_IALIGN  = 7'd0;  // Jump target misaligned
    localparam logic [TRAP_CAUSE_W-1:0] TRAP_EBRK    = 7'd3;  // Breakpoint
    localparam logic [TRAP_CAUSE_W-1:0] TRAP_LDALIGN = 7'd4;  // Load address misaligned
    localparam logic [TRAP_CAUSE_W-1:0] TRAP_LDFAULT = 7'd5;  // Load access fault
    localparam logic [TRAP_CAUSE_W-1:0] TRAP_STALIGN = 7'd6;  // Store address misaligned
    localparam logic [TRAP_CAUSE_W-1:0] TRAP_STFAULT = 7'd7;  // Store access fault
    localparam logic [TRAP_CAUSE_W-1:0] TRAP_ECALL   = 7'd11; // Environment call

endpackage

`default_nettype wire

// ==== common/exec_pipe_pkg.sv ====
/*
 * Execute stage pipeline definitions
 * Data memory widths, writeback source and load/store unit states
 */
`default_nettype none

package exec_pipe_pkg;

    localparam int MEM_ADDR_W = 32;           // Data memory address width
    localparam int MEM_STRB_W = 4;            // One strobe per byte lane

    // Writeback data source
    typedef enum logic [1:0] {
        WB_ALU,                               // ALU result
        WB_NPC,                               // Link address
        WB_LSU                                // Loaded data
    } wb_src_e;

    // Load/store sequencing
    typedef enum logic [1:0] {
        LSU_IDLE,                             // No request yet
        LSU_REQ,                              // Waiting for grant
        LSU_DONE                              // Response captured
    } lsu_state_e;

endpackage

`default_nettype wire

// ==== exec_alu/exec_alu.sv ====
/*
 * Integer ALU
 * Adder and comparators run every cycle, result picked by alu_op
 */
`default_nettype none

module exec_alu import exec_isa_pkg::*; (
    input  alu_op_e         alu_op,           // Operation select
    input  logic [XLEN-1:0] lhs,              // Left operand
    input  logic [XLEN-1:0] rhs,              // Right operand
    alu_res_if.src          res               // Results to the units
);

    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;
    logic [4:0]      shamt;

    assign sum   = lhs + rhs;
    assign diff  = lhs - rhs;
    assign shamt = rhs[4:0];                  // Low five bits only

    // Shared outputs
    // --------------------
    assign res.add_out = sum;                 // Addresses and link math
    assign res.cmp_eq  = (lhs == rhs);
    assign res.cmp_lt  = ($signed(lhs) < $signed(rhs));
    assign res.cmp_ltu = (lhs < rhs);

    // Result select
    // --------------------
    always_comb begin
        case (alu_op)
            ALU_ADD:  res.result = sum;
            ALU_SUB:  res.result = diff;
            ALU_AND:  res.result = lhs & rhs;
            ALU_OR:   res.result = lhs | rhs;
            ALU_XOR:  res.result = lhs ^ rhs;
            ALU_SLT:  res.result = {{(XLEN-1){1'b0}}, res.cmp_lt};
            ALU_SLTU: res.result = {{(XLEN-1){1'b0}}, res.cmp_ltu};
            ALU_SLL:  res.result = lhs << shamt;
            ALU_SRL:  res.result = lhs >> shamt;
            ALU_SRA:  res.result = $unsigned($signed(lhs) >>> shamt); // Keeps sign
            default:  res.result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== exec_cfu/exec_cfu.sv ====
/*
 * Control-flow unit
 * Resolves branches and jumps, redirects fetch, raises control-flow traps
 */
`default_nettype none

module exec_cfu import exec_isa_pkg::*; (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  logic                    valid,          // Stage 2 holds an instruction
    input  logic                    accept,         // Instruction leaves stage 2
    input  cfu_op_e                 cfu_op,         // Control-flow operation
    input  logic [XLEN-1:0]         pc,             // Instruction address
    input  logic [XLEN-1:0]         imm,            // Branch or jump offset
    input  logic [XLEN-1:0]         lhs,            // Base for jalr
    alu_res_if.snk                  res,            // Comparison results
    output logic                    cf_valid,       // Fetch redirect request
    input  logic                    cf_ack,         // Fetch took the redirect
    output logic [XLEN-1:0]         cf_target,      // Redirect address
    output logic                    done,
    output logic                    trap,
    output logic [TRAP_CAUSE_W-1:0] trap_cause
);

    logic taken;
    logic is_jump;
    logic is_env;
    logic redirect;
    logic tgt_misalign;
    logic redirected_q;                             // Ack seen for this instruction

    // Branch resolution
    // --------------------
    always_comb begin
        case (cfu_op)
            CFU_BEQ:  taken = res.cmp_eq;
            CFU_BNE:  taken = !res.cmp_eq;
            CFU_BLT:  taken = res.cmp_lt;
            CFU_BGE:  taken = !res.cmp_lt;
            CFU_BLTU: taken = res.cmp_ltu;
            CFU_BGEU: taken = !res.cmp_ltu;
            default:  taken = 1'b0;
        endcase
    end

    assign is_jump  = (cfu_op == CFU_JAL) || (cfu_op == CFU_JALR);
    assign is_env   = (cfu_op == CFU_ECALL) || (cfu_op == CFU_EBRK);
    assign redirect = is_jump || taken;

    // jalr clears bit 0 of its target
    assign cf_target = (cfu_op == CFU_JALR) ? ((lhs + imm) & ~XLEN'(1)) : (pc + imm);

    assign tgt_misalign = redirect && (cf_target[1:0] != 2'b00);

    // Redirect handshake
    // --------------------
    assign cf_valid = valid && redirect && !tgt_misalign && !redirected_q;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            redirected_q <= 1'b0;
        end else if (accept) begin
            redirected_q <= 1'b0;                   // Next instruction starts clean
        end else if (cf_valid && cf_ack) begin
            redirected_q <= 1'b1;
        end
    end

    assign done = !redirect || tgt_misalign || redirected_q;
    assign trap = is_env || tgt_misalign;

    always_comb begin
        case (cfu_op)
            CFU_ECALL: trap_cause = TRAP_ECALL;
            CFU_EBRK:  trap_cause = TRAP_EBRK;
            default:   trap_cause = TRAP_IALIGN;
        endcase
    end

endmodule

`default_nettype wire

// ==== exec_lsu/exec_lsu.sv ====
/*
 * Load/store unit
 * Sequences one data memory request, forms strobes and store lanes,
 * aligns and extends load data, raises alignment and access traps
 */
`default_nettype none

module exec_lsu import exec_isa_pkg::*, exec_pipe_pkg::*; (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  logic                    valid,          // Stage 2 holds an instruction
    input  logic                    accept,         // Instruction leaves stage 2
    input  lsu_op_e                 lsu_op,         // Load/store operation
    input  logic [XLEN-1:0]         store_data,     // rs2 value
    alu_res_if.snk                  res,            // Address from the adder
    output logic                    dmem_req,
    output logic                    dmem_wen,
    output logic [MEM_ADDR_W-1:0]   dmem_addr,
    output logic [MEM_STRB_W-1:0]   dmem_strb,
    output logic [XLEN-1:0]         dmem_wdata,
    input  logic                    dmem_gnt,
    input  logic                    dmem_err,
    input  logic [XLEN-1:0]         dmem_rdata,
    output logic                    done,
    output logic [XLEN-1:0]         rdata,          // Aligned, extended load value
    output logic                    trap,
    output logic [TRAP_CAUSE_W-1:0] trap_cause
);

    lsu_state_e      state;
    logic            is_load;
    logic            is_store;
    logic            misalign;
    logic [XLEN-1:0] lane;
    logic [XLEN-1:0] ext;
    logic [XLEN-1:0] rdata_q;
    logic            err_q;

    assign is_load  = lsu_op inside {LSU_LB, LSU_LBU, LSU_LH, LSU_LHU, LSU_LW};
    assign is_store = lsu_op inside {LSU_SB, LSU_SH, LSU_SW};
    assign misalign = ((lsu_op inside {LSU_LW, LSU_SW}) && (res.add_out[1:0] != 2'b00)) ||
                      ((lsu_op inside {LSU_LH, LSU_LHU, LSU_SH}) && res.add_out[0]);

    // Request fields
    // --------------------
    assign dmem_req   = (state == LSU_REQ);
    assign dmem_wen   = is_store;
    assign dmem_addr  = res.add_out[MEM_ADDR_W-1:0];

    always_comb begin
        case (lsu_op)
            LSU_LB, LSU_LBU, LSU_SB: begin
                dmem_strb  = 4'b0001 << res.add_out[1:0];
                dmem_wdata = {(XLEN/8){store_data[7:0]}};   // Every lane
            end
            LSU_LH, LSU_LHU, LSU_SH: begin
                dmem_strb  = 4'b0011 << {res.add_out[1], 1'b0};
                dmem_wdata = {(XLEN/16){store_data[15:0]}};
            end
            default: begin
                dmem_strb  = 4'b1111;
                dmem_wdata = store_data;
            end
        endcase
    end

    // Load alignment
    // --------------------
    assign lane = dmem_rdata >> {res.add_out[1:0], 3'b000};   // Addressed byte to bit 0

    always_comb begin
        case (lsu_op)
            LSU_LB:  ext = {{(XLEN-8){lane[7]}}, lane[7:0]};
            LSU_LBU: ext = {{(XLEN-8){1'b0}}, lane[7:0]};
            LSU_LH:  ext = {{(XLEN-16){lane[15]}}, lane[15:0]};
            LSU_LHU: ext = {{(XLEN-16){1'b0}}, lane[15:0]};
            default: ext = lane;
        endcase
    end

    // Request FSM
    // --------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state <= LSU_IDLE;
        end else begin
            case (state)
                LSU_IDLE: if (valid && (is_load || is_store) && !misalign) state <= LSU_REQ;
                LSU_REQ:  if (dmem_gnt) state <= LSU_DONE;
                LSU_DONE: if (accept) state <= LSU_IDLE;
                default:  state <= LSU_IDLE;
            endcase
        end
    end

    always_ff @(posedge g_clk) begin
        if (dmem_req && dmem_gnt) begin
            rdata_q <= ext;                         // Response valid with grant
            err_q   <= dmem_err;
        end
    end

    assign rdata = rdata_q;
    assign done  = !(is_load || is_store) || misalign || (state == LSU_DONE);
    assign trap  = misalign || ((state == LSU_DONE) && err_q);

    always_comb begin
        if (is_load) begin
            trap_cause = misalign ? TRAP_LDALIGN : TRAP_LDFAULT;
        end else begin
            trap_cause = misalign ? TRAP_STALIGN : TRAP_STFAULT;
        end
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
common/exec_isa_pkg.sv
common/exec_pipe_pkg.sv
common/alu_res_if.sv
exec_alu/exec_alu.sv
exec_cfu/exec_cfu.sv
exec_lsu/exec_lsu.sv
src/exec_wb_reg.sv
src/core_pipe_exec.sv
tb/core_pipe_exec_chk.sv
tb/core_pipe_exec_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
    --top-module core_pipe_exec_tb \
    -f filelist.f \
    -o core_pipe_exec_tb
./obj_dir/core_pipe_exec_tb

// ==== src/core_pipe_exec.sv ====
/*
 * Execute stage top
 * ALU, control-flow and load/store units feeding the stage 3 register
 */
`default_nettype none

module core_pipe_exec import exec_isa_pkg::*, exec_pipe_pkg::*; (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  logic                    s2_valid,       // Decode has an instruction
    output logic                    s2_ready,
    input  logic [XLEN-1:0]         s2_pc,
    input  logic [XLEN-1:0]         s2_npc,
    input  logic [REG_ADDR_W-1:0]   s2_rd,
    input  logic [XLEN-1:0]         s2_alu_lhs,
    input  logic [XLEN-1:0]         s2_alu_rhs,
    input  logic [XLEN-1:0]         s2_imm,
    input  logic [XLEN-1:0]         s2_rs2_data,    // Store data
    input  alu_op_e                 s2_alu_op,
    input  cfu_op_e                 s2_cfu_op,
    input  lsu_op_e                 s2_lsu_op,
    input  wb_src_e                 s2_wb_src,
    output logic                    s2_cf_valid,    // Fetch redirect
    input  logic                    s2_cf_ack,
    output logic [XLEN-1:0]         s2_cf_target,
    output logic                    dmem_req,
    output logic                    dmem_wen,
    output logic [MEM_ADDR_W-1:0]   dmem_addr,
    output logic [MEM_STRB_W-1:0]   dmem_strb,
    output logic [XLEN-1:0]         dmem_wdata,
    input  logic                    dmem_gnt,
    input  logic                    dmem_err,
    input  logic [XLEN-1:0]         dmem_rdata,
    input  logic                    s3_ready,       // Writeback can take a record
    output logic                    s3_valid,
    output logic [XLEN-1:0]         s3_pc,
    output logic [REG_ADDR_W-1:0]   s3_rd,
    output logic [XLEN-1:0]         s3_wdata,
    output logic                    s3_trap,
    output logic [TRAP_CAUSE_W-1:0] s3_trap_cause
);

    logic                    accept;
    logic                    cfu_done;
    logic                    cfu_trap;
    logic [TRAP_CAUSE_W-1:0] cfu_trap_cause;
    logic                    lsu_done;
    logic                    lsu_trap;
    logic [TRAP_CAUSE_W-1:0] lsu_trap_cause;
    logic [XLEN-1:0]         lsu_rdata;

    alu_res_if alu_res ();

    // Units
    // --------------------
    exec_alu exec_alu_i (
        .alu_op (s2_alu_op), .lhs (s2_alu_lhs), .rhs (s2_alu_rhs), .res (alu_res.src)
    );

    exec_cfu exec_cfu_i (
        .g_clk      (g_clk),        .g_resetn   (g_resetn),
        .valid      (s2_valid),     .accept     (accept),
        .cfu_op     (s2_cfu_op),    .pc         (s2_pc),
        .imm        (s2_imm),       .lhs        (s2_alu_lhs),
        .res        (alu_res.snk),  .cf_valid   (s2_cf_valid),
        .cf_ack     (s2_cf_ack),    .cf_target  (s2_cf_target),
        .done       (cfu_done),     .trap       (cfu_trap),
        .trap_cause (cfu_trap_cause)
    );

    exec_lsu exec_lsu_i (
        .g_clk      (g_clk),        .g_resetn   (g_resetn),
        .valid      (s2_valid),     .accept     (accept),
        .lsu_op     (s2_lsu_op),    .store_data (s2_rs2_data),
        .res        (alu_res.snk),  .dmem_req   (dmem_req),
        .dmem_wen   (dmem_wen),     .dmem_addr  (dmem_addr),
        .dmem_strb  (dmem_strb),    .dmem_wdata (dmem_wdata),
        .dmem_gnt   (dmem_gnt),     .dmem_err   (dmem_err),
        .dmem_rdata (dmem_rdata),   .done       (lsu_done),
        .rdata      (lsu_rdata),    .trap       (lsu_trap),
        .trap_cause (lsu_trap_cause)
    );

    // Handover and record
    // --------------------
    exec_wb_reg exec_wb_reg_i (
        .g_clk          (g_clk),          .g_resetn       (g_resetn),
        .s2_valid       (s2_valid),       .s2_ready       (s2_ready),
        .accept         (accept),         .s2_pc          (s2_pc),
        .s2_npc         (s2_npc),         .s2_rd          (s2_rd),
        .wb_src         (s2_wb_src),      .res            (alu_res.snk),
        .cfu_done       (cfu_done),       .cfu_trap       (cfu_trap),
        .cfu_trap_cause (cfu_trap_cause), .lsu_done       (lsu_done),
        .lsu_trap       (lsu_trap),       .lsu_trap_cause (lsu_trap_cause),
        .lsu_rdata      (lsu_rdata),      .s3_ready       (s3_ready),
        .s3_valid       (s3_valid),       .s3_pc          (s3_pc),
        .s3_rd          (s3_rd),          .s3_wdata       (s3_wdata),
        .s3_trap        (s3_trap),        .s3_trap_cause  (s3_trap_cause)
    );

endmodule

`default_nettype wire

// ==== src/exec_wb_reg.sv ====
/*
 * Stage 3 register
 * Decides when stage 2 hands over and captures the writeback record
 */
`default_nettype none

module exec_wb_reg import exec_isa_pkg::*, exec_pipe_pkg::*; (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  logic                    s2_valid,
    output logic                    s2_ready,
    output logic                    accept,         // Handover this cycle
    input  logic [XLEN-1:0]         s2_pc,
    input  logic [XLEN-1:0]         s2_npc,
    input  logic [REG_ADDR_W-1:0]   s2_rd,
    input  wb_src_e                 wb_src,         // Write data source
    alu_res_if.snk                  res,
    input  logic                    cfu_done,
    input  logic                    cfu_trap,
    input  logic [TRAP_CAUSE_W-1:0] cfu_trap_cause,
    input  logic                    lsu_done,
    input  logic                    lsu_trap,
    input  logic [TRAP_CAUSE_W-1:0] lsu_trap_cause,
    input  logic [XLEN-1:0]         lsu_rdata,
    input  logic                    s3_ready,
    output logic                    s3_valid,
    output logic [XLEN-1:0]         s3_pc,
    output logic [REG_ADDR_W-1:0]   s3_rd,
    output logic [XLEN-1:0]         s3_wdata,
    output logic                    s3_trap,
    output logic [TRAP_CAUSE_W-1:0] s3_trap_cause
);

    logic [XLEN-1:0] wdata;

    // Stage 3 empty or draining, every unit finished
    assign accept   = s2_valid && cfu_done && lsu_done && (!s3_valid || s3_ready);
    assign s2_ready = accept;

    always_comb begin
        case (wb_src)
            WB_NPC:  wdata = s2_npc;                // Link address
            WB_LSU:  wdata = lsu_rdata;
            default: wdata = res.result;
        endcase
    end

    // Record register
    // --------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            s3_valid <= 1'b0;
        end else if (accept) begin
            s3_valid <= 1'b1;
        end else if (s3_ready) begin
            s3_valid <= 1'b0;                       // Drained, nothing new
        end
    end

    always_ff @(posedge g_clk) begin
        if (accept) begin
            s3_pc         <= s2_pc;
            s3_rd         <= s2_rd;
            s3_wdata      <= wdata;
            s3_trap       <= cfu_trap || lsu_trap;
            s3_trap_cause <= cfu_trap ? cfu_trap_cause : lsu_trap_cause; // CFU first
        end
    end

endmodule

`default_nettype wire

// ==== tb/core_pipe_exec_chk.sv ====
/*
 * Execute stage handshake checker
 * Bound into the top level, watches memory, fetch and stage 3 ports
 */
`default_nettype none

module core_pipe_exec_chk import exec_isa_pkg::*, exec_pipe_pkg::*; (
    input logic g_clk, g_resetn, dmem_req, dmem_wen, dmem_gnt,
    input logic [MEM_ADDR_W-1:0] dmem_addr,
    input logic [MEM_STRB_W-1:0] dmem_strb,
    input logic [XLEN-1:0] dmem_wdata, s2_cf_target, s3_pc, s3_wdata,
    input logic s2_cf_valid, s2_cf_ack, s3_valid, s3_ready, s3_trap,
    input logic [REG_ADDR_W-1:0] s3_rd,
    input logic [TRAP_CAUSE_W-1:0] s3_trap_cause
);
    timeunit 1ns;
    timeprecision 100ps;

    a_dmem_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
        dmem_req && !dmem_gnt |=> dmem_req && $stable({dmem_addr, dmem_wen, dmem_strb, dmem_wdata}))
        else $error("dmem request changed before grant");

    a_cf_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
        s2_cf_valid && !s2_cf_ack |=> s2_cf_valid && $stable(s2_cf_target))
        else $error("fetch redirect changed before ack");

    a_s3_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
        s3_valid && !s3_ready |=> s3_valid &&
            $stable({s3_pc, s3_rd, s3_wdata, s3_trap, s3_trap_cause}))
        else $error("stage 3 record changed under back-pressure");

    // Word needs 4-byte, half needs 2-byte alignment
    a_no_misalign: assert property (@(posedge g_clk) disable iff (!g_resetn)
        dmem_req |-> (dmem_strb != 4'hf || dmem_addr[1:0] == 2'b00) &&
                     (!(dmem_strb inside {4'h3, 4'hc}) || !dmem_addr[0]))
        else $error("dmem request for a misaligned address");

endmodule

`default_nettype wire

// ==== tb/core_pipe_exec_tb.sv ====
/*
 * Execute stage testbench
 * Table driven stimulus with memory and fetch responders, random back-pressure
 */
`default_nettype none

module core_pipe_exec_tb import exec_isa_pkg::*, exec_pipe_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct {
        alu_op_e alu;
        cfu_op_e cfu;
        lsu_op_e lsu;
        wb_src_e src;
        logic [XLEN-1:0] lhs, rhs, imm, rs2, wdata, tgt;
        logic [REG_ADDR_W-1:0] rd;
        logic trap;
        logic [TRAP_CAUSE_W-1:0] cause;
        logic [MEM_STRB_W-1:0] strb;                 // Zero when no access is expected
    } entry_t;

    logic g_clk, g_resetn, s2_valid, s2_ready, s2_cf_valid, s2_cf_ack;
    logic dmem_req, dmem_wen, dmem_gnt, dmem_err, s3_ready, s3_valid, s3_trap;
    logic [XLEN-1:0] s2_pc, s2_npc, s2_alu_lhs, s2_alu_rhs, s2_imm, s2_rs2_data, s2_cf_target;
    logic [XLEN-1:0] dmem_wdata, dmem_rdata, s3_pc, s3_wdata;
    logic [MEM_ADDR_W-1:0] dmem_addr;
    logic [MEM_STRB_W-1:0] dmem_strb;
    logic [REG_ADDR_W-1:0] s2_rd, s3_rd;
    logic [TRAP_CAUSE_W-1:0] s3_trap_cause;
    alu_op_e s2_alu_op;
    cfu_op_e s2_cfu_op;
    lsu_op_e s2_lsu_op;
    wb_src_e s2_wb_src;
    entry_t  tbl[$];
    int      exp_q[$];                               // Table indices in flight
    logic [XLEN-1:0] mem [64];
    integer  seed = 32'h8387;
    int      cur = 0, cycles = 0, limit = 0;
    int      acked_idx = -1;                         // Last entry whose redirect was acked

    core_pipe_exec core_pipe_exec_i (.*);
    bind core_pipe_exec core_pipe_exec_chk core_pipe_exec_chk_i (.*);

    initial begin
        g_clk = 1'b0;
        forever #2 g_clk = ~g_clk;                   // 4 ns period
    end

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_data(input logic [XLEN-1:0] got_wd, exp_wd,
                              input logic [REG_ADDR_W-1:0] got_rd, exp_rd);
        if (got_wd !== exp_wd || got_rd !== exp_rd)
            report_error($sformatf("Mismatch at %0t: wdata %h rd %0d, expected %h rd %0d",
                                   $time, got_wd, got_rd, exp_wd, exp_rd));
    endtask

    task automatic check_pc(input logic [XLEN-1:0] got, exp);
        if (got !== exp)
            report_error($sformatf("Mismatch at %0t: pc %h, expected %h", $time, got, exp));
    endtask

    task automatic check_trap(input logic got, exp, input logic [TRAP_CAUSE_W-1:0] gc, ec);
        if (got !== exp || (exp && gc !== ec))
            report_error($sformatf("Mismatch at %0t: trap %b cause %0d, expected %b cause %0d",
                                   $time, got, gc, exp, ec));
    endtask

    task automatic check_target(input logic [XLEN-1:0] got, exp);
        if (got !== exp)
            report_error($sformatf("Mismatch at %0t: redirect %h, expected %h", $time, got, exp));
    endtask

    task automatic check_strb(input logic [MEM_STRB_W-1:0] got, exp);
        if (got !== exp)
            report_error($sformatf("Mismatch at %0t: strobes %b, expected %b", $time, got, exp));
    endtask

    // Cause -1 means no trap, tgt 0 means no redirect
    task automatic add(input alu_op_e a, input cfu_op_e c, input lsu_op_e l, input wb_src_e s,
                       input logic [XLEN-1:0] lhs, rhs, imm, rs2,
                       input int rd, input logic [XLEN-1:0] wd, input int cause,
                       input logic [XLEN-1:0] tgt, input int strb);
        entry_t e;
        e = '{a, c, l, s, lhs, rhs, imm, rs2, wd, tgt, REG_ADDR_W'(rd), cause >= 0,
              TRAP_CAUSE_W'(cause), MEM_STRB_W'(strb)};
        tbl.push_back(e);
    endtask

    // Memory responder
    // --------------------
    initial begin
        int n;
        for (int i = 0; i < 64; i++) mem[i] = 32'(i) * 32'h01010101;  // Per-word pattern
        forever begin
            @(negedge g_clk);
            if (dmem_req) begin
                if (tbl[cur].strb == '0) report_error("Unexpected data memory request");
                check_strb(dmem_strb, tbl[cur].strb);
                n = {$random(seed)} % 4;
                repeat (n + 1) @(posedge g_clk);
                #1 dmem_gnt = 1'b1;
                dmem_err   = (dmem_addr >= 32'h100);
                dmem_rdata = dmem_err ? '0 : mem[dmem_addr[7:2]];
                @(posedge g_clk);
                #1 dmem_gnt = 1'b0;
                if (dmem_wen && !dmem_err)
                    for (int b = 0; b < 4; b++)
                        if (dmem_strb[b]) mem[dmem_addr[7:2]][8*b +: 8] = dmem_wdata[8*b +: 8];
            end
        end
    end

    // Fetch responder
    // --------------------
    initial begin
        int n;
        forever begin
            @(negedge g_clk);
            if (s2_cf_valid) begin
                if (tbl[cur].tgt == '0) report_error("Unexpected fetch redirect");
                check_target(s2_cf_target, tbl[cur].tgt);
                n = {$random(seed)} % 4;
                repeat (n + 1) @(posedge g_clk);
                #1 s2_cf_ack = 1'b1;
                @(posedge g_clk);
                acked_idx = cur;
                #1 s2_cf_ack = 1'b0;
            end
        end
    end

    initial begin
        forever begin
            @(posedge g_clk);
            #1 s3_ready = (($random(seed) & 3) != 0); // Ready three times in four
        end
    end

    // Stage 3 monitor
    // --------------------
    initial begin
        entry_t e;
        int     idx;
        forever begin
            @(negedge g_clk);
            if (s3_valid && s3_ready) begin
                if (exp_q.size() == 0) report_error("Stage 3 record with nothing expected");
                idx = exp_q.pop_front();
                e = tbl[idx];
                check_pc(s3_pc, 32'h1000 + 32'(4 * idx));
                check_trap(s3_trap, e.trap, s3_trap_cause, e.cause);
                if (!e.trap) check_data(s3_wdata, e.wdata, s3_rd, e.rd);
            end
        end
    end

    initial begin
        wait (limit != 0);
        while (cycles < limit) @(posedge g_clk) cycles++;
        $display("Timeout after %0d cycles, records still pending", cycles);
        $display("Simulation failed");
        $fatal(1);
    end

    initial begin
        {s2_valid, s2_cf_ack, dmem_gnt, dmem_err, s3_ready} = '0;
        {s2_pc, s2_npc, s2_alu_lhs, s2_alu_rhs, s2_imm, s2_rs2_data, dmem_rdata} = '0;
        s2_rd = '0;
        s2_alu_op = ALU_ADD;
        s2_cfu_op = CFU_NONE;
        s2_lsu_op = LSU_NONE;
        s2_wb_src = WB_ALU;
        g_resetn = 1'b0;
        add(ALU_ADD,  CFU_NONE, LSU_NONE, WB_ALU, 'h5, 'h7, 0, 0, 1, 'hc, -1, 0, 0);
        add(ALU_SUB,  CFU_NONE, LSU_NONE, WB_ALU, 'h3, 'h5, 0, 0, 2, 'hfffffffe, -1, 0, 0);
        add(ALU_XOR,  CFU_NONE, LSU_NONE, WB_ALU, 'ha5a5a5a5, 'hffff0000, 0, 0, 3,
            'h5a5aa5a5, -1, 0, 0);
        add(ALU_SLT,  CFU_NONE, LSU_NONE, WB_ALU, 'hffffffff, 'h1, 0, 0, 4, 'h1, -1, 0, 0);
        add(ALU_SLTU, CFU_NONE, LSU_NONE, WB_ALU, 'hffffffff, 'h1, 0, 0, 5, 'h0, -1, 0, 0);
        add(ALU_SRA,  CFU_NONE, LSU_NONE, WB_ALU, 'h80000000, 'h4, 0, 0, 6, 'hf8000000, -1, 0, 0);
        add(ALU_SLL,  CFU_NONE, LSU_NONE, WB_ALU, 'h1, 'd33, 0, 0, 7, 'h2, -1, 0, 0);
        add(ALU_SUB,  CFU_BEQ,  LSU_NONE, WB_ALU, 'h3, 'h3, 'h20, 0, 0, 'h0, -1, 'h103c, 0);
        add(ALU_SUB,  CFU_BLT,  LSU_NONE, WB_ALU, 'hffffffff, 'h1, 'hfffffff8, 0, 0,
            'hfffffffe, -1, 'h1018, 0);
        add(ALU_SUB,  CFU_BLTU, LSU_NONE, WB_ALU, 'hffffffff, 'h1, 'h40, 0, 0,
            'hfffffffe, -1, 0, 0);                   // Not taken
        add(ALU_ADD,  CFU_JAL,  LSU_NONE, WB_NPC, 0, 0, 'h100, 0, 1, 'h102c, -1, 'h1128, 0);
        add(ALU_ADD,  CFU_JALR, LSU_NONE, WB_NPC, 'h2001, 0, 'h10, 0, 2, 'h1030, -1, 'h2010, 0);
        add(ALU_ADD,  CFU_NONE, LSU_SW,  WB_ALU, 'h40, 0, 0, 'h8badf00d, 0, 'h40, -1, 0, 'hf);
        add(ALU_ADD,  CFU_NONE, LSU_LB,  WB_LSU, 'h40, 3, 0, 0, 3, 'hffffff8b, -1, 0, 'h8);
        add(ALU_ADD,  CFU_NONE, LSU_LBU, WB_LSU, 'h40, 1, 0, 0, 4, 'hf0, -1, 0, 'h2);
        add(ALU_ADD,  CFU_NONE, LSU_LH,  WB_LSU, 'h40, 2, 0, 0, 5, 'hffff8bad, -1, 0, 'hc);
        add(ALU_ADD,  CFU_NONE, LSU_LHU, WB_LSU, 'h40, 0, 0, 0, 6, 'hf00d, -1, 0, 'h3);
        add(ALU_ADD,  CFU_NONE, LSU_LW,  WB_LSU, 'h40, 0, 0, 0, 7, 'h8badf00d, -1, 0, 'hf);
        add(ALU_ADD,  CFU_NONE, LSU_SB,  WB_ALU, 'h44, 1, 0, 'h7e, 0, 'h45, -1, 0, 'h2);
        add(ALU_ADD,  CFU_NONE, LSU_LW,  WB_LSU, 'h44, 0, 0, 0, 8, 'h11117e11, -1, 0, 'hf);
        add(ALU_ADD,  CFU_NONE, LSU_LW,  WB_LSU, 'h40, 2, 0, 0, 9, 0, 4, 0, 0);
        add(ALU_ADD,  CFU_NONE, LSU_SH,  WB_ALU, 'h44, 1, 0, 0, 0, 0, 6, 0, 0);
        add(ALU_ADD,  CFU_NONE, LSU_LW,  WB_LSU, 'h100, 0, 0, 0, 9, 0, 5, 0, 'hf);
        add(ALU_ADD,  CFU_NONE, LSU_SW,  WB_ALU, 'h104, 0, 0, 0, 0, 0, 7, 0, 'hf);
        add(ALU_ADD,  CFU_JAL,  LSU_NONE, WB_NPC, 0, 0, 'h102, 0, 1, 0, 0, 0, 0);
        add(ALU_ADD,  CFU_ECALL, LSU_NONE, WB_ALU, 0, 0, 0, 0, 0, 0, 11, 0, 0);
        add(ALU_ADD,  CFU_EBRK, LSU_NONE, WB_ALU, 0, 0, 0, 0, 0, 0, 3, 0, 0);
        add(ALU_AND,  CFU_NONE, LSU_NONE, WB_ALU, 'hf0f0f0f0, 'h0ff00ff0, 0, 0, 8,
            'h00f000f0, -1, 0, 0);
        add(ALU_OR,   CFU_NONE, LSU_NONE, WB_ALU, 'hf0f00000, 'h0000ff0f, 0, 0, 9,
            'hf0f0ff0f, -1, 0, 0);
        add(ALU_SRL,  CFU_NONE, LSU_NONE, WB_ALU, 'h80000000, 'h4, 0, 0, 10, 'h08000000, -1, 0, 0);
        limit = tbl.size() * 40 + 10;
        repeat (10) @(posedge g_clk);
        #1 g_resetn = 1'b1;
        for (int i = 0; i < tbl.size(); i++) begin
            cur = i;                                 // Responders look up this entry
            s2_valid = 1'b1;
            s2_pc = 32'h1000 + 32'(4 * i);
            s2_npc = s2_pc + 32'd4;
            s2_rd = tbl[i].rd;
            {s2_alu_lhs, s2_alu_rhs, s2_imm, s2_rs2_data} =
                {tbl[i].lhs, tbl[i].rhs, tbl[i].imm, tbl[i].rs2};
            s2_alu_op = tbl[i].alu;
            s2_cfu_op = tbl[i].cfu;
            s2_lsu_op = tbl[i].lsu;
            s2_wb_src = tbl[i].src;
            do @(negedge g_clk); while (!s2_ready);
            if (tbl[i].tgt != '0 && acked_idx != i)
                report_error("Taken branch or jump finished without a fetch redirect");
            exp_q.push_back(i);
            @(posedge g_clk);
            #1;
        end
        s2_valid = 1'b0;
        while (exp_q.size() != 0) @(posedge g_clk);
        @(posedge g_clk);
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire
